// File: design/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
	parameter int DATA_WORDS = 256
) (
	input logic i_clock,
	input logic i_rst,
	input logic i_stall,

	input logic [cpu_pkg::TAG_WIDTH-1:0] i_tag,
	input logic [cpu_pkg::XLEN-1:0] i_pc,
	input logic [cpu_pkg::XLEN-1:0] i_instruction,
	output logic o_fetch_ready,

	output logic o_branch,
	output logic [cpu_pkg::XLEN-1:0] o_pc_next,

	output logic o_wb_valid,
	output logic [4:0] o_wb_rd,
	output logic [cpu_pkg::XLEN-1:0] o_wb_data
);

	// decode to execute
	logic [cpu_pkg::TAG_WIDTH-1:0] d_tag;
	logic [cpu_pkg::XLEN-1:0] d_pc;
	logic [cpu_pkg::XLEN-1:0] d_instruction;
	logic [cpu_pkg::XLEN-1:0] d_rs1;
	logic [cpu_pkg::XLEN-1:0] d_rs2;
	logic [4:0] d_inst_rd;
	logic [cpu_pkg::XLEN-1:0] d_imm;
	logic d_branch;

	// register file reads
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [cpu_pkg::XLEN-1:0] rs1_data;
	logic [cpu_pkg::XLEN-1:0] rs2_data;

	// execute to memory
	logic [cpu_pkg::TAG_WIDTH-1:0] e_tag;
	logic [4:0] e_inst_rd;
	logic [4:0] e_load_rd;
	logic [cpu_pkg::XLEN-1:0] e_rd;
	logic e_mem_read;
	logic e_mem_write;
	cpu_pkg::mem_width_t e_mem_width;
	logic e_mem_signed;
	logic [cpu_pkg::XLEN-1:0] e_mem_address;

	// writeback is committed once per new tag
	logic [cpu_pkg::TAG_WIDTH-1:0] wb_tag;
	logic [cpu_pkg::TAG_WIDTH-1:0] last_wb_tag;
	logic wb_write;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			last_wb_tag <= '0;
		end else begin
			last_wb_tag <= wb_tag;
		end
	end

	assign wb_write = o_wb_valid && (wb_tag != last_wb_tag);

	cpu_decode u_decode (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_stall(i_stall),
		.i_tag(i_tag),
		.i_pc(i_pc),
		.i_instruction(i_instruction),
		.o_fetch_ready(o_fetch_ready),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_ex_rd(e_inst_rd),
		.i_ex_value(e_rd),
		.i_wb_valid(o_wb_valid),
		.i_wb_rd(o_wb_rd),
		.i_wb_data(o_wb_data),
		.o_tag(d_tag),
		.o_pc(d_pc),
		.o_instruction(d_instruction),
		.o_rs1(d_rs1),
		.o_rs2(d_rs2),
		.o_inst_rd(d_inst_rd),
		.o_imm(d_imm),
		.o_branch(d_branch)
	);

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_stall(i_stall),
		.i_tag(d_tag),
		.i_pc(d_pc),
		.i_instruction(d_instruction),
		.i_rs1(d_rs1),
		.i_rs2(d_rs2),
		.i_inst_rd(d_inst_rd),
		.i_imm(d_imm),
		.i_branch(d_branch),
		.o_tag(e_tag),
		.o_inst_rd(e_inst_rd),
		.o_load_rd(e_load_rd),
		.o_rd(e_rd),
		.o_branch(o_branch),
		.o_pc_next(o_pc_next),
		.o_mem_read(e_mem_read),
		.o_mem_write(e_mem_write),
		.o_mem_width(e_mem_width),
		.o_mem_signed(e_mem_signed),
		.o_mem_address(e_mem_address)
	);

	cpu_memory #(
		.DATA_WORDS(DATA_WORDS)
	) u_memory (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_stall(i_stall),
		.i_tag(e_tag),
		.i_inst_rd(e_inst_rd),
		.i_load_rd(e_load_rd),
		.i_rd(e_rd),
		.i_mem_read(e_mem_read),
		.i_mem_write(e_mem_write),
		.i_mem_width(e_mem_width),
		.i_mem_signed(e_mem_signed),
		.i_mem_address(e_mem_address),
		.o_wb_valid(o_wb_valid),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data),
		.o_wb_tag(wb_tag)
	);

	cpu_register_file u_register_file (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_wr_en(wb_write),
		.i_wr_addr(o_wb_rd),
		.i_wr_data(o_wb_data)
	);

endmodule

// File: design/cpu_decode.sv
`timescale 1ns/100ps

module cpu_decode (
	input logic i_clock,
	input logic i_rst,
	input logic i_stall,

	// from fetch
	input logic [cpu_pkg::TAG_WIDTH-1:0] i_tag,
	input logic [cpu_pkg::XLEN-1:0] i_pc,
	input logic [cpu_pkg::XLEN-1:0] i_instruction,
	output logic o_fetch_ready,

	// register file
	output logic [4:0] o_rs1_addr,
	output logic [4:0] o_rs2_addr,
	input logic [cpu_pkg::XLEN-1:0] i_rs1_data,
	input logic [cpu_pkg::XLEN-1:0] i_rs2_data,

	// forwarding sources
	input logic [4:0] i_ex_rd,
	input logic [cpu_pkg::XLEN-1:0] i_ex_value,
	input logic i_wb_valid,
	input logic [4:0] i_wb_rd,
	input logic [cpu_pkg::XLEN-1:0] i_wb_data,

	// to execute
	output logic [cpu_pkg::TAG_WIDTH-1:0] o_tag,
	output logic [cpu_pkg::XLEN-1:0] o_pc,
	output logic [cpu_pkg::XLEN-1:0] o_instruction,
	output logic [cpu_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_pkg::XLEN-1:0] o_rs2,
	output logic [4:0] o_inst_rd,
	output logic [cpu_pkg::XLEN-1:0] o_imm,
	output logic o_branch
);

	cpu_pkg::inst_word_u in_word;
	cpu_pkg::inst_word_u held_word;
	logic [6:0] opcode;
	logic [cpu_pkg::XLEN-1:0] imm;
	logic uses_rs1;
	logic uses_rs2;
	logic writes_rd;
	logic is_branch;
	logic new_inst;
	logic hazard;
	logic take;
	logic load_pending;
	logic [4:0] load_rd;

	assign in_word = i_instruction;
	assign held_word = o_instruction;
	assign opcode = in_word.r_fmt.opcode;

	////////////////////////////////////////////////////////////////////////////
	// format decode and immediate

	always_comb begin
		imm = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		writes_rd = 1'b0;
		is_branch = 1'b0;
		case (opcode)
			cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC: begin
				imm = {in_word.u_fmt.imm_31_12, 12'b0};
				writes_rd = 1'b1;
			end
			cpu_pkg::OPC_JAL: begin
				imm = {{11{in_word.j_fmt.imm_20}}, in_word.j_fmt.imm_20,
					in_word.j_fmt.imm_19_12, in_word.j_fmt.imm_11,
					in_word.j_fmt.imm_10_1, 1'b0};
				writes_rd = 1'b1;
				is_branch = 1'b1;
			end
			cpu_pkg::OPC_JALR, cpu_pkg::OPC_LOAD, cpu_pkg::OPC_OP_IMM: begin
				imm = {{20{in_word.i_fmt.imm_11_0[11]}}, in_word.i_fmt.imm_11_0};
				uses_rs1 = 1'b1;
				writes_rd = 1'b1;
				is_branch = (opcode == cpu_pkg::OPC_JALR);
			end
			cpu_pkg::OPC_BRANCH: begin
				imm = {{19{in_word.b_fmt.imm_12}}, in_word.b_fmt.imm_12,
					in_word.b_fmt.imm_11, in_word.b_fmt.imm_10_5,
					in_word.b_fmt.imm_4_1, 1'b0};
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				is_branch = 1'b1;
			end
			cpu_pkg::OPC_STORE: begin
				imm = {{20{in_word.s_fmt.imm_11_5[6]}}, in_word.s_fmt.imm_11_5,
					in_word.s_fmt.imm_4_0};
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			cpu_pkg::OPC_OP: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				writes_rd = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// load result only shows up on writeback two stages later
	assign new_inst = (i_tag != o_tag);
	assign hazard = load_pending && new_inst &&
		((uses_rs1 && in_word.r_fmt.rs1 == load_rd) ||
		(uses_rs2 && in_word.r_fmt.rs2 == load_rd));
	assign o_fetch_ready = !hazard;
	assign take = o_fetch_ready && !i_stall && new_inst;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_tag <= '0;
			o_inst_rd <= '0;
			o_branch <= 1'b0;
			load_pending <= 1'b0;
		end else if (!i_stall) begin
			load_pending <= take && opcode == cpu_pkg::OPC_LOAD &&
				in_word.r_fmt.rd != 5'd0;
			if (take) begin
				o_tag <= i_tag;
				o_pc <= i_pc;
				o_instruction <= i_instruction;
				o_imm <= imm;
				o_inst_rd <= writes_rd ? in_word.r_fmt.rd : 5'd0;
				o_branch <= is_branch;
				load_rd <= in_word.r_fmt.rd;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// operand read with forwarding, execute first

	assign o_rs1_addr = held_word.r_fmt.rs1;
	assign o_rs2_addr = held_word.r_fmt.rs2;

	function automatic logic [cpu_pkg::XLEN-1:0] forward(input logic [4:0] addr,
			input logic [cpu_pkg::XLEN-1:0] rf_value);
		if (addr != 5'd0 && addr == i_ex_rd) begin
			return i_ex_value;
		end else if (addr != 5'd0 && i_wb_valid && addr == i_wb_rd) begin
			return i_wb_data;
		end
		return rf_value;
	endfunction

	always_comb begin
		o_rs1 = forward(o_rs1_addr, i_rs1_data);
		o_rs2 = forward(o_rs2_addr, i_rs2_data);
	end

endmodule

// File: design/cpu_execute.sv
`timescale 1ns/100ps

module cpu_execute (
	input logic i_clock,
	input logic i_rst,
	input logic i_stall,

	input logic [cpu_pkg::TAG_WIDTH-1:0] i_tag,
	input logic [cpu_pkg::XLEN-1:0] i_pc,
	input logic [cpu_pkg::XLEN-1:0] i_instruction,
	input logic [cpu_pkg::XLEN-1:0] i_rs1,
	input logic [cpu_pkg::XLEN-1:0] i_rs2,
	input logic [4:0] i_inst_rd,
	input logic [cpu_pkg::XLEN-1:0] i_imm,
	input logic i_branch,

	output logic [cpu_pkg::TAG_WIDTH-1:0] o_tag,
	output logic [4:0] o_inst_rd,
	output logic [4:0] o_load_rd,
	output logic [cpu_pkg::XLEN-1:0] o_rd,

	output logic o_branch,
	output logic [cpu_pkg::XLEN-1:0] o_pc_next,

	output logic o_mem_read,
	output logic o_mem_write,
	output cpu_pkg::mem_width_t o_mem_width,
	output logic o_mem_signed,
	output logic [cpu_pkg::XLEN-1:0] o_mem_address
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	logic [cpu_pkg::XLEN-1:0] alu_b;
	logic [cpu_pkg::XLEN-1:0] sra_value;
	logic [cpu_pkg::XLEN-1:0] alu_result;
	logic [cpu_pkg::XLEN-1:0] addr_sum;
	logic [cpu_pkg::XLEN-1:0] pc_imm;
	logic [cpu_pkg::XLEN-1:0] pc_plus4;
	logic eq;
	logic lt;
	logic ltu;
	logic taken;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign alt = i_instruction[30];

	////////////////////////////////////////////////////////////////////////////
	// alu and compare

	assign alu_b = (opcode == cpu_pkg::OPC_OP) ? i_rs2 : i_imm;
	assign sra_value = $signed(i_rs1) >>> alu_b[4:0];

	always_comb begin
		case (funct3)
			cpu_pkg::F3_ADD: begin
				// addi never subtracts
				alu_result = (opcode == cpu_pkg::OPC_OP && alt) ? i_rs1 - alu_b : i_rs1 + alu_b;
			end
			cpu_pkg::F3_SLL: alu_result = i_rs1 << alu_b[4:0];
			cpu_pkg::F3_SLT: alu_result = {31'b0, $signed(i_rs1) < $signed(alu_b)};
			cpu_pkg::F3_SLTU: alu_result = {31'b0, i_rs1 < alu_b};
			cpu_pkg::F3_XOR: alu_result = i_rs1 ^ alu_b;
			cpu_pkg::F3_SR: alu_result = alt ? sra_value : i_rs1 >> alu_b[4:0];
			cpu_pkg::F3_OR: alu_result = i_rs1 | alu_b;
			cpu_pkg::F3_AND: alu_result = i_rs1 & alu_b;
			default: alu_result = '0;
		endcase
	end

	assign eq = (i_rs1 == i_rs2);
	assign lt = ($signed(i_rs1) < $signed(i_rs2));
	assign ltu = (i_rs1 < i_rs2);

	always_comb begin
		case (funct3)
			cpu_pkg::F3_BEQ: taken = eq;
			cpu_pkg::F3_BNE: taken = !eq;
			cpu_pkg::F3_BLT: taken = lt;
			cpu_pkg::F3_BGE: taken = !lt;
			cpu_pkg::F3_BLTU: taken = ltu;
			cpu_pkg::F3_BGEU: taken = !ltu;
			default: taken = 1'b0;
		endcase
	end

	assign addr_sum = i_rs1 + i_imm;
	assign pc_imm = i_pc + i_imm;
	assign pc_plus4 = i_pc + 32'd4;

	////////////////////////////////////////////////////////////////////////////
	// stage register, acts once per new tag

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_tag <= '0;
			o_inst_rd <= '0;
			o_branch <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
		end else if (!i_stall && i_tag != o_tag) begin
			o_branch <= i_branch;
			o_pc_next <= pc_plus4;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_mem_width <= cpu_pkg::MW_NONE;
			o_mem_signed <= 1'b0;
			o_mem_address <= addr_sum;
			o_inst_rd <= i_inst_rd;
			o_rd <= alu_result;

			case (opcode)
				cpu_pkg::OPC_LUI: o_rd <= i_imm;
				cpu_pkg::OPC_AUIPC: o_rd <= pc_imm;
				cpu_pkg::OPC_JAL: begin
					o_rd <= pc_plus4;
					o_pc_next <= pc_imm;
				end
				cpu_pkg::OPC_JALR: begin
					o_rd <= pc_plus4;
					o_pc_next <= {addr_sum[31:1], 1'b0};
				end
				cpu_pkg::OPC_BRANCH: begin
					if (taken) begin
						o_pc_next <= pc_imm;
					end
				end
				cpu_pkg::OPC_LOAD: begin
					// hide the load from forwarding, its rd rides on o_load_rd
					o_mem_read <= 1'b1;
					o_inst_rd <= 5'd0;
					o_load_rd <= i_inst_rd;
					case (funct3)
						cpu_pkg::F3_LB: begin
							o_mem_width <= cpu_pkg::MW_BYTE;
							o_mem_signed <= 1'b1;
						end
						cpu_pkg::F3_LBU: o_mem_width <= cpu_pkg::MW_BYTE;
						cpu_pkg::F3_LH: begin
							o_mem_width <= cpu_pkg::MW_HALF;
							o_mem_signed <= 1'b1;
						end
						cpu_pkg::F3_LHU: o_mem_width <= cpu_pkg::MW_HALF;
						cpu_pkg::F3_LW: o_mem_width <= cpu_pkg::MW_WORD;
						default: begin
						end
					endcase
				end
				cpu_pkg::OPC_STORE: begin
					o_mem_write <= 1'b1;
					o_rd <= i_rs2;
					case (funct3)
						cpu_pkg::F3_SB: o_mem_width <= cpu_pkg::MW_BYTE;
						cpu_pkg::F3_SH: o_mem_width <= cpu_pkg::MW_HALF;
						cpu_pkg::F3_SW: o_mem_width <= cpu_pkg::MW_WORD;
						default: begin
						end
					endcase
				end
				default: begin
				end
			endcase

			o_tag <= i_tag;
		end
	end

endmodule

// File: design/cpu_memory.sv
`timescale 1ns/100ps

module cpu_memory #(
	parameter int DATA_WORDS = 256
) (
	input logic i_clock,
	input logic i_rst,
	input logic i_stall,

	input logic [cpu_pkg::TAG_WIDTH-1:0] i_tag,
	input logic [4:0] i_inst_rd,
	input logic [4:0] i_load_rd,
	input logic [cpu_pkg::XLEN-1:0] i_rd,
	input logic i_mem_read,
	input logic i_mem_write,
	input cpu_pkg::mem_width_t i_mem_width,
	input logic i_mem_signed,
	input logic [cpu_pkg::XLEN-1:0] i_mem_address,

	output logic o_wb_valid,
	output logic [4:0] o_wb_rd,
	output logic [cpu_pkg::XLEN-1:0] o_wb_data,
	output logic [cpu_pkg::TAG_WIDTH-1:0] o_wb_tag
);

	localparam int ADDR_BITS = $clog2(DATA_WORDS);

	logic [cpu_pkg::XLEN-1:0] ram [DATA_WORDS];
	logic [ADDR_BITS-1:0] word_index;
	logic [1:0] lane;
	logic [3:0] lane_mask;
	logic [3:0] byte_en;
	logic [cpu_pkg::XLEN-1:0] store_data;
	logic [cpu_pkg::XLEN-1:0] load_word;
	logic [cpu_pkg::XLEN-1:0] load_value;
	logic act;

	assign act = !i_stall && i_tag != o_wb_tag;
	assign word_index = i_mem_address[ADDR_BITS+1:2];

	// lane offset from the low address bits
	always_comb begin
		case (i_mem_width)
			cpu_pkg::MW_BYTE: begin
				lane = i_mem_address[1:0];
				lane_mask = 4'b0001;
			end
			cpu_pkg::MW_HALF: begin
				lane = {i_mem_address[1], 1'b0};
				lane_mask = 4'b0011;
			end
			default: begin
				lane = 2'd0;
				lane_mask = 4'b1111;
			end
		endcase
	end

	assign byte_en = lane_mask << lane;
	assign store_data = i_rd << {lane, 3'b000};
	assign load_word = ram[word_index] >> {lane, 3'b000};

	always_comb begin
		case (i_mem_width)
			cpu_pkg::MW_BYTE: load_value = {{24{i_mem_signed && load_word[7]}}, load_word[7:0]};
			cpu_pkg::MW_HALF: load_value = {{16{i_mem_signed && load_word[15]}}, load_word[15:0]};
			default: load_value = load_word;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (act && i_mem_write) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i]) begin
					ram[word_index][i*8 +: 8] <= store_data[i*8 +: 8];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// writeback register

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_wb_tag <= '0;
			o_wb_valid <= 1'b0;
		end else if (act) begin
			o_wb_tag <= i_tag;
			if (i_mem_read) begin
				o_wb_valid <= (i_load_rd != 5'd0);
				o_wb_rd <= i_load_rd;
				o_wb_data <= load_value;
			end else begin
				// stores and branches arrive with rd zero
				o_wb_valid <= (i_inst_rd != 5'd0);
				o_wb_rd <= i_inst_rd;
				o_wb_data <= i_rd;
			end
		end
	end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int TAG_WIDTH = 8;

	// major opcodes
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;

	// branch conditions
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load and store sizes
	localparam logic [2:0] F3_LB = 3'b000;
	localparam logic [2:0] F3_LH = 3'b001;
	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// alu operations, bit 30 picks sub and sra
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// memory access width as a byte count
	typedef logic [2:0] mem_width_t;
	localparam mem_width_t MW_NONE = 3'd0;
	localparam mem_width_t MW_BYTE = 3'd1;
	localparam mem_width_t MW_HALF = 3'd2;
	localparam mem_width_t MW_WORD = 3'd4;

	////////////////////////////////////////////////////////////////////////////
	// instruction word formats

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_word_u;

endpackage

// File: design/cpu_register_file.sv
`timescale 1ns/100ps

module cpu_register_file (
	input logic i_clock,
	input logic i_rst,
	input logic [4:0] i_rs1_addr,
	input logic [4:0] i_rs2_addr,
	output logic [cpu_pkg::XLEN-1:0] o_rs1_data,
	output logic [cpu_pkg::XLEN-1:0] o_rs2_data,
	input logic i_wr_en,
	input logic [4:0] i_wr_addr,
	input logic [cpu_pkg::XLEN-1:0] i_wr_data
);

	// x0 has no storage
	logic [cpu_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_addr != 5'd0) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

// File: flist.f
design/cpu_pkg.sv
design/cpu_register_file.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_memory.sv
design/cpu_core.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_core -f flist.f

./obj_dir/Vtb_cpu_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_rst
);

	// 8 ns period
	initial begin
		o_clock = 1'b0;
		forever #4 o_clock = ~o_clock;
	end

	// release on a falling edge after three rising edges
	initial begin
		o_rst = 1'b1;
		repeat (3) @(posedge o_clock);
		@(negedge o_clock);
		o_rst = 1'b0;
	end

endmodule

// File: testbench/tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core;

	localparam int TOTAL_INSTR = 574;
	localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR + 200;

	logic clock;
	logic rst;
	logic i_stall;
	logic [7:0] i_tag;
	logic [31:0] i_pc;
	logic [31:0] i_instruction;
	logic o_fetch_ready;
	logic o_branch;
	logic [31:0] o_pc_next;
	logic o_wb_valid;
	logic [4:0] o_wb_rd;
	logic [31:0] o_wb_data;

	// reference state
	logic [31:0] rf [32];
	logic [7:0] mem_b [1024];
	logic [36:0] wb_q [$];
	logic [32:0] br_q [$];
	logic [31:0] lfsr;
	logic [31:0] pc;
	logic [7:0] tag;
	logic [4:0] last_rd;
	logic stall_en;
	string test_name;
	int cycles;
	int low_cycles;
	logic [7:0] last_e_tag;
	logic [7:0] last_wb_tag;
	logic prev_rst;

	tb_clock_gen u_clock_gen (
		.o_clock(clock),
		.o_rst(rst)
	);

	cpu_core #(
		.DATA_WORDS(256)
	) i_dut (
		.i_clock(clock),
		.i_rst(rst),
		.i_stall(i_stall),
		.i_tag(i_tag),
		.i_pc(i_pc),
		.i_instruction(i_instruction),
		.o_fetch_ready(o_fetch_ready),
		.o_branch(o_branch),
		.o_pc_next(o_pc_next),
		.o_wb_valid(o_wb_valid),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// random numbers and reporting

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [4:0] r;
		r = 5'(rand_bits(5));
		return (r == 5'd0) ? 5'd1 : r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s during %s", what, test_name);
			$display("TEST RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model retiring in program order

	function automatic logic [31:0] alu(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b, input logic sub, input logic arith);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return arith ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic model_exec(input logic [31:0] w, input logic [31:0] pc_v);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] res;
		logic [31:0] next;
		logic [9:0] ad;
		logic wr;
		logic br;
		a = rf[w[19:15]];
		b = rf[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		res = '0;
		wr = 1'b0;
		br = 1'b0;
		next = pc_v + 32'd4;
		case (w[6:0])
			cpu_pkg::OPC_OP: begin
				res = alu(w[14:12], a, b, w[30], w[30]);
				wr = 1'b1;
			end
			cpu_pkg::OPC_OP_IMM: begin
				res = alu(w[14:12], a, imm_i, 1'b0, w[30]);
				wr = 1'b1;
			end
			cpu_pkg::OPC_LUI: begin
				res = {w[31:12], 12'b0};
				wr = 1'b1;
			end
			cpu_pkg::OPC_AUIPC: begin
				res = pc_v + {w[31:12], 12'b0};
				wr = 1'b1;
			end
			cpu_pkg::OPC_JAL: begin
				res = pc_v + 32'd4;
				next = pc_v + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				wr = 1'b1;
				br = 1'b1;
			end
			cpu_pkg::OPC_JALR: begin
				res = pc_v + 32'd4;
				next = (a + imm_i) & ~32'd1;
				wr = 1'b1;
				br = 1'b1;
			end
			cpu_pkg::OPC_BRANCH: begin
				br = 1'b1;
				if (branch_taken(w[14:12], a, b)) begin
					next = pc_v + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			cpu_pkg::OPC_LOAD: begin
				ad = 10'(a + imm_i);
				wr = 1'b1;
				case (w[14:12])
					3'b000: res = {{24{mem_b[ad][7]}}, mem_b[ad]};
					3'b100: res = {24'b0, mem_b[ad]};
					3'b001: res = {{16{mem_b[ad+1][7]}}, mem_b[ad+1], mem_b[ad]};
					3'b101: res = {16'b0, mem_b[ad+1], mem_b[ad]};
					default: res = {mem_b[ad+3], mem_b[ad+2], mem_b[ad+1], mem_b[ad]};
				endcase
			end
			cpu_pkg::OPC_STORE: begin
				ad = 10'(a + imm_s);
				mem_b[ad] = b[7:0];
				if (w[14:12] != 3'b000) begin
					mem_b[ad+1] = b[15:8];
				end
				if (w[14:12] == 3'b010) begin
					mem_b[ad+2] = b[23:16];
					mem_b[ad+3] = b[31:24];
				end
			end
			default: begin
			end
		endcase
		if (wr && w[11:7] != 5'd0) begin
			wb_q.push_back({w[11:7], res});
			rf[w[11:7]] = res;
		end
		br_q.push_back({br, next});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// feeder sends one instruction and returns once decode has taken it

	task automatic send(input logic [31:0] word);
		int n;
		if (stall_en && rand_bits(2) == 0) begin
			n = 1 + int'(rand_bits(3));
			i_stall = 1'b1;
			repeat (n) @(negedge clock);
			i_stall = 1'b0;
		end
		model_exec(word, pc);
		tag = (tag == 8'hff) ? 8'h01 : tag + 8'h01;
		i_tag = tag;
		i_pc = pc;
		i_instruction = word;
		pc = pc + 32'd4;
		@(negedge clock);
		while (i_dut.d_tag !== i_tag) begin
			@(negedge clock);
		end
	endtask

	task automatic gen_alu();
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] imm;
		logic alt;
		f3 = 3'(rand_bits(3));
		rd = rand_reg();
		rs1 = rand_bits(1) ? last_rd : rand_reg();
		rs2 = rand_bits(1) ? last_rd : rand_reg();
		alt = 1'(rand_bits(1));
		if (rand_bits(1)) begin
			alt = alt && (f3 == cpu_pkg::F3_ADD || f3 == cpu_pkg::F3_SR);
			send({1'b0, alt, 5'b0, rs2, rs1, f3, rd, cpu_pkg::OPC_OP});
		end else begin
			imm = 12'(rand_bits(12));
			if (f3 == cpu_pkg::F3_SLL) begin
				imm = {7'b0, imm[4:0]};
			end else if (f3 == cpu_pkg::F3_SR) begin
				imm = {1'b0, alt, 5'b0, imm[4:0]};
			end
			send({imm, rs1, f3, rd, cpu_pkg::OPC_OP_IMM});
		end
		last_rd = rd;
	endtask

	task automatic store_at(input logic [11:0] ad, input logic [2:0] f3);
		send({ad[11:5], rand_reg(), 5'd0, f3, ad[4:0], cpu_pkg::OPC_STORE});
	endtask

	task automatic load_at(input logic [11:0] ad, input logic [2:0] f3, input logic [4:0] rd);
		send({ad, 5'd0, f3, rd, cpu_pkg::OPC_LOAD});
	endtask

	// word fill then halfword and byte overwrite then read back
	task automatic mem_round();
		logic [11:0] base;
		logic [4:0] rd;
		base = 12'(rand_bits(8)) << 2;
		store_at(base, cpu_pkg::F3_SW);
		store_at(base + (12'(rand_bits(1)) << 1), cpu_pkg::F3_SH);
		store_at(base + 12'(rand_bits(2)), cpu_pkg::F3_SB);
		load_at(base + 12'(rand_bits(2)), rand_bits(1) ? cpu_pkg::F3_LB : cpu_pkg::F3_LBU,
			rand_reg());
		load_at(base + (12'(rand_bits(1)) << 1), rand_bits(1) ? cpu_pkg::F3_LH : cpu_pkg::F3_LHU,
			rand_reg());
		rd = rand_reg();
		load_at(base, cpu_pkg::F3_LW, rd);
		send({7'b0, rand_reg(), rd, cpu_pkg::F3_ADD, rand_reg(), cpu_pkg::OPC_OP});
	endtask

	task automatic branch_round();
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [12:0] off;
		logic [20:0] joff;
		for (int i = 0; i < 8; i++) begin
			if (i != 2 && i != 3) begin
				repeat (8) begin
					rs1 = rand_reg();
					rs2 = (rand_bits(2) == 0) ? rs1 : rand_reg();
					off = 13'(rand_bits(12)) << 1;
					send({off[12], off[10:5], rs2, rs1, 3'(i), off[4:1], off[11],
						cpu_pkg::OPC_BRANCH});
				end
			end
		end
		repeat (8) begin
			joff = 21'(rand_bits(20)) << 1;
			send({joff[20], joff[10:1], joff[11], joff[19:12], rand_reg(), cpu_pkg::OPC_JAL});
		end
		repeat (8) begin
			send({12'(rand_bits(12)), rand_reg(), 3'b000, rand_reg(), cpu_pkg::OPC_JALR});
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors

	always @(posedge clock) begin
		#1;
		if (rst || prev_rst) begin
			check_true(!o_wb_valid && !o_branch && o_fetch_ready, "bad output state at reset");
		end
		if (!rst) begin
			if (i_dut.e_tag != last_e_tag) begin
				check_true(br_q.size() != 0, "execute took an instruction never sent");
				check_value({test_name, " o_branch"}, 32'(br_q[0][32]), 32'(o_branch));
				if (br_q[0][32]) begin
					check_value({test_name, " o_pc_next"}, br_q[0][31:0], o_pc_next);
				end
				void'(br_q.pop_front());
			end
			if (i_dut.wb_tag != last_wb_tag) begin
				check_true(!i_stall, "new writeback while stalled");
				if (o_wb_valid) begin
					check_true(wb_q.size() != 0, "writeback that the model did not expect");
					check_value({test_name, " wb_rd"}, 32'(wb_q[0][36:32]), 32'(o_wb_rd));
					check_value({test_name, " wb_data"}, wb_q[0][31:0], o_wb_data);
					void'(wb_q.pop_front());
				end
			end
		end
		last_e_tag = i_dut.e_tag;
		last_wb_tag = i_dut.wb_tag;
		prev_rst = rst;
	end

	always @(negedge clock) begin
		#1;
		if (!rst && !o_fetch_ready) begin
			low_cycles++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		int low_before;
		i_stall = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_instruction = '0;
		lfsr = 32'hb6da;
		pc = 32'h1000;
		tag = '0;
		last_rd = 5'd1;
		stall_en = 1'b0;
		cycles = 0;
		low_cycles = 0;
		last_e_tag = '0;
		last_wb_tag = '0;
		prev_rst = 1'b1;
		test_name = "reset";
		for (int i = 0; i < 32; i++) begin
			rf[i] = '0;
		end
		wait (rst == 1'b0);
		@(negedge clock);

		test_name = "setup";
		for (int r = 1; r < 32; r++) begin
			send({20'(rand_bits(20)), 5'(r), cpu_pkg::OPC_LUI});
			send({12'(rand_bits(12)), 5'(r), cpu_pkg::F3_ADD, 5'(r), cpu_pkg::OPC_OP_IMM});
		end

		test_name = "alu";
		repeat (200) gen_alu();
		repeat (10) begin
			send({20'(rand_bits(20)), rand_reg(), cpu_pkg::OPC_LUI});
			send({20'(rand_bits(20)), rand_reg(), cpu_pkg::OPC_AUIPC});
		end

		test_name = "load_store";
		low_before = low_cycles;
		repeat (24) mem_round();
		check_value({test_name, " load_use_hold"}, 32'd24, 32'(low_cycles - low_before));

		test_name = "branch";
		branch_round();

		test_name = "back_pressure";
		stall_en = 1'b1;
		repeat (60) gen_alu();
		stall_en = 1'b0;

		repeat (12) @(negedge clock);
		if (wb_q.size() == 0 && br_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("%0d writebacks and %0d executions never seen", wb_q.size(), br_q.size());
			$display("TEST RESULT: FAIL");
			$fatal(1, "missing results");
		end
	end

endmodule
